// File: tb.f
hw/cpu_pkg.sv
hw/cpu_ctrl_if.sv
hw/instr_fetch.sv
hw/instr_decoder.sv
hw/control_fsm.sv
hw/operand_regs.sv
hw/alu_result.sv
hw/cpu_top.sv
bench/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the CPU testbench with Verilator; exit status follows the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cpu -f tb.f -o sim_tb_cpu

./obj_dir/sim_tb_cpu | tee sim.log

grep -q '^>>> PASS$' sim.log
echo "simulation passed"

// File: bench/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W      = 8;
    localparam int PROG_LEN    = 6;
    localparam int RST_CYCLES  = 3;
    localparam int HOLD_CYCLES = 4;  // out must stay put this long after halt
    localparam int CLK_PERIOD  = 8;
    localparam int N_TESTS     = 7;

    // every instruction counted at the six-cycle worst case
    localparam int WD_NS = 2 * N_TESTS * (PROG_LEN + RST_CYCLES + 6 * PROG_LEN) * CLK_PERIOD;

    typedef struct packed {
        logic [ADDR_W-1:0]         start_pc;
        logic [0:PROG_LEN-1][15:0] prog;  // unused slots padded with halt
        logic [15:0]               exp_out;
    } test_t;

    // opcode[15:13] op[12:11] rn[10:8], then imm8 or rd[7:5] shift[4:3] rm[2:0]
    localparam test_t TESTS [N_TESTS] = '{
        // mov r1,#0x85 then mov r2,r1
        '{8'h00, '{16'hD185, 16'hC041, 16'hE000, 16'hE000, 16'hE000, 16'hE000}, 16'hFF85},
        // r3=0x0040, r4=0xFFF0, add r5,r3,r4 lsl #1 drops the carry
        '{8'h00, '{16'hD340, 16'hD4F0, 16'hA3AC, 16'hE000, 16'hE000, 16'hE000}, 16'h0020},
        // and r3,r1,r2 with 0x003C and 0xFFF5
        '{8'h10, '{16'hD13C, 16'hD2F5, 16'hB162, 16'hE000, 16'hE000, 16'hE000}, 16'h0034},
        // mvn r7,r6 lsl #1 with r6=0x0012
        '{8'h20, '{16'hD612, 16'hB8EE, 16'hE000, 16'hE000, 16'hE000, 16'hE000}, 16'hFFDB},
        // lsr of 0xFF80 fills with zero
        '{8'h00, '{16'hD180, 16'hC051, 16'hE000, 16'hE000, 16'hE000, 16'hE000}, 16'h7FC0},
        // asr of 0xFF80 keeps the sign
        '{8'h00, '{16'hD180, 16'hC059, 16'hE000, 16'hE000, 16'hE000, 16'hE000}, 16'hFFC0},
        // no-op cmp before halt in a program at a nonzero start
        '{8'hA0, '{16'hD17E, 16'hC049, 16'hAA01, 16'hE000, 16'hE000, 16'hE000}, 16'h00FC}
    };

    logic              clk = 1'b0;
    logic              rst_n;
    logic [ADDR_W-1:0] start_pc;
    logic              prog_we;
    logic [ADDR_W-1:0] prog_addr;
    logic [15:0]       prog_data;
    logic [15:0]       out;
    logic              halted;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_top #(.ADDR_W(ADDR_W)) i_dut (
        .clk(clk), .rst_n(rst_n), .start_pc(start_pc),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .out(out), .halted(halted)
    );

    task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // reset held the whole time the program port is in use
    task automatic load_program(input test_t tc);
        @(negedge clk);
        rst_n    = 1'b1;
        start_pc = tc.start_pc;
        for (int w = 0; w < PROG_LEN; w++) begin
            prog_we   = 1'b1;
            prog_addr = ADDR_W'(tc.start_pc + w);
            prog_data = tc.prog[w];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
    endtask

    task automatic run_test(input int t);
        test_t tc;
        tc = TESTS[t];
        load_program(tc);
        check_equal(out, 16'h0000, $sformatf("test %0d out in reset", t));
        check_equal(16'(halted), 16'h0000, $sformatf("test %0d halted in reset", t));
        rst_n = 1'b0; // release
        while (!halted) begin
            @(negedge clk);
        end
        check_equal(out, tc.exp_out, $sformatf("test %0d out at halt", t));
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_equal(out, tc.exp_out, $sformatf("test %0d out after halt", t));
            check_equal(16'(halted), 16'h0001, $sformatf("test %0d halted level", t));
        end
    endtask

    initial begin
        rst_n     = 1'b1;
        start_pc  = '0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(WD_NS);
        $display("timeout, the tests did not finish in time");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: hw/cpu_top.sv
module cpu_top #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [ADDR_W-1:0]   start_pc,
    input  logic                prog_we,
    input  logic [ADDR_W-1:0]   prog_addr,
    input  cpu_pkg::word_t      prog_data,
    output cpu_pkg::word_t      out,
    output logic                halted
);

    cpu_pkg::instr_u   ir;
    cpu_pkg::opcode_e  opcode;
    cpu_pkg::alu_op_e  op;
    cpu_pkg::shift_e   shift;
    cpu_pkg::reg_idx_t reg_idx;
    cpu_pkg::word_t    imm8_sx;
    cpu_pkg::word_t    a_val;
    cpu_pkg::word_t    b_val;
    logic              load_ir;

    cpu_ctrl_if ctrl ();

    instr_fetch #(.ADDR_W(ADDR_W)) i_fetch (
        .clk(clk), .rst_n(rst_n), .start_pc(start_pc),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .load_ir(load_ir), .ir(ir)
    );

    instr_decoder i_dec (
        .ir(ir), .reg_sel(ctrl.reg_sel), .opcode(opcode), .op(op),
        .shift(shift), .reg_idx(reg_idx), .imm8_sx(imm8_sx)
    );

    control_fsm i_fsm (
        .clk(clk), .rst_n(rst_n), .opcode(opcode), .op(op),
        .ctrl(ctrl.seq), .load_ir(load_ir), .halted(halted)
    );

    operand_regs i_regs (
        .clk(clk), .reg_idx(reg_idx), .imm8_sx(imm8_sx), .result(out),
        .ctrl(ctrl.dp), .a_val(a_val), .b_val(b_val)
    );

    alu_result i_alu (
        .clk(clk), .rst_n(rst_n), .a_val(a_val), .b_val(b_val),
        .shift(shift), .ctrl(ctrl.dp), .result(out)
    );

endmodule

// File: hw/alu_result.sv
module alu_result (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::word_t  a_val,
    input  cpu_pkg::word_t  b_val,
    input  cpu_pkg::shift_e shift,
    cpu_ctrl_if.dp          ctrl,
    output cpu_pkg::word_t  result
);

    localparam int MSB = cpu_pkg::DATA_W - 1;

    cpu_pkg::word_t b_sh;
    cpu_pkg::word_t op_a;
    cpu_pkg::word_t alu_out;

    always_comb begin
        case (shift)
            cpu_pkg::SH_LSL: b_sh = {b_val[MSB-1:0], 1'b0};
            cpu_pkg::SH_LSR: b_sh = {1'b0, b_val[MSB:1]};
            cpu_pkg::SH_ASR: b_sh = {b_val[MSB], b_val[MSB:1]}; // keep sign
            default:         b_sh = b_val;
        endcase
    end

    assign op_a = ctrl.sel_a ? '0 : a_val;

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_out = op_a + b_sh; // carry dropped
            cpu_pkg::ALU_AND: alu_out = op_a & b_sh;
            cpu_pkg::ALU_MVN: alu_out = ~b_sh;
            default:          alu_out = '0;
        endcase
    end

    // register C, drives out and the writeback mux
    always_ff @(posedge clk) begin
        if (rst_n) begin
            result <= '0;
        end else if (ctrl.en_c) begin
            result <= alu_out;
        end
    end

endmodule

// File: hw/operand_regs.sv
module operand_regs (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t reg_idx,
    input  cpu_pkg::word_t    imm8_sx,
    input  cpu_pkg::word_t    result,
    cpu_ctrl_if.dp            ctrl,
    output cpu_pkg::word_t    a_val,
    output cpu_pkg::word_t    b_val
);

    localparam int NUM_REGS = 2**cpu_pkg::REG_ADDR_W;

    cpu_pkg::word_t rf [NUM_REGS];
    cpu_pkg::word_t rd_data;
    cpu_pkg::word_t wb_data;

    assign rd_data = rf[reg_idx]; // combinational read port
    assign wb_data = (ctrl.wb_sel == cpu_pkg::WB_IMM8) ? imm8_sx : result;

    // single port, read and write share reg_idx
    always_ff @(posedge clk) begin
        if (ctrl.w_en) begin
            rf[reg_idx] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.en_a) begin
            a_val <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.en_b) begin
            b_val <= rd_data;
        end
    end

endmodule

// File: hw/control_fsm.sv
module control_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::opcode_e  opcode,
    input  cpu_pkg::alu_op_e  op,
    cpu_ctrl_if.seq           ctrl,
    output logic              load_ir,
    output logic              halted
);

    cpu_pkg::state_e  state;
    cpu_pkg::state_e  next_state;
    cpu_pkg::alu_op_e alu_op_q;
    cpu_pkg::alu_op_e alu_op_d;
    logic             mov_imm_q;
    logic             mov_imm_d;
    logic             zero_a_q;
    logic             zero_a_d;

    always_comb begin
        next_state = state;
        mov_imm_d  = (opcode == cpu_pkg::OP_MOV) && (op == cpu_pkg::MOV_IMM);
        zero_a_d   = (opcode == cpu_pkg::OP_MOV) || (op == cpu_pkg::ALU_MVN);
        alu_op_d   = (opcode == cpu_pkg::OP_MOV) ? cpu_pkg::ALU_ADD : op; // mov reg is 0 + b
        case (state)
            cpu_pkg::FETCH:  next_state = cpu_pkg::DECODE;
            cpu_pkg::DECODE: begin
                case (opcode)
                    cpu_pkg::OP_MOV: begin
                        if (op == cpu_pkg::MOV_IMM) next_state = cpu_pkg::WRITE;
                        else if (op == cpu_pkg::MOV_REG) next_state = cpu_pkg::LOAD_B;
                        else next_state = cpu_pkg::FETCH;
                    end
                    cpu_pkg::OP_ALU: begin
                        if (op == cpu_pkg::ALU_MVN) next_state = cpu_pkg::LOAD_B;
                        else if (op == cpu_pkg::ALU_ADD || op == cpu_pkg::ALU_AND)
                            next_state = cpu_pkg::LOAD_A;
                        else next_state = cpu_pkg::FETCH; // cmp
                    end
                    cpu_pkg::OP_HALT: next_state = cpu_pkg::HALT;
                    default:          next_state = cpu_pkg::FETCH; // no-op encodings
                endcase
            end
            cpu_pkg::LOAD_A: next_state = cpu_pkg::LOAD_B;
            cpu_pkg::LOAD_B: next_state = cpu_pkg::EXEC;
            cpu_pkg::EXEC:   next_state = cpu_pkg::WRITE;
            cpu_pkg::WRITE:  next_state = cpu_pkg::FETCH;
            cpu_pkg::HALT:   next_state = cpu_pkg::HALT;
            default:         next_state = cpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state     <= cpu_pkg::FETCH;
            alu_op_q  <= cpu_pkg::ALU_ADD;
            mov_imm_q <= 1'b0;
            zero_a_q  <= 1'b0;
        end else begin
            state <= next_state;
            if (state == cpu_pkg::DECODE) begin // path fixed here
                alu_op_q  <= alu_op_d;
                mov_imm_q <= mov_imm_d;
                zero_a_q  <= zero_a_d;
            end
        end
    end

    assign load_ir     = (state == cpu_pkg::FETCH);
    assign halted      = (state == cpu_pkg::HALT);
    assign ctrl.alu_op = alu_op_q;
    assign ctrl.en_a   = (state == cpu_pkg::LOAD_A);
    assign ctrl.en_b   = (state == cpu_pkg::LOAD_B);
    assign ctrl.en_c   = (state == cpu_pkg::EXEC);
    assign ctrl.sel_a  = (state == cpu_pkg::EXEC) && zero_a_q;
    assign ctrl.w_en   = (state == cpu_pkg::WRITE);
    assign ctrl.wb_sel = mov_imm_q ? cpu_pkg::WB_IMM8 : cpu_pkg::WB_RESULT;

    always_comb begin
        case (state)
            cpu_pkg::LOAD_A: ctrl.reg_sel = cpu_pkg::SEL_RN;
            cpu_pkg::LOAD_B: ctrl.reg_sel = cpu_pkg::SEL_RM;
            cpu_pkg::WRITE:  ctrl.reg_sel = mov_imm_q ? cpu_pkg::SEL_RN : cpu_pkg::SEL_RD;
            default:         ctrl.reg_sel = cpu_pkg::SEL_RM;
        endcase
    end

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (rst_n)
        state == cpu_pkg::HALT |=> state == cpu_pkg::HALT
    ) else $error("left HALT without reset");

    // C must not move while the register file takes it
    a_no_wr_and_exec: assert property (
        @(posedge clk) !(ctrl.w_en && ctrl.en_c)
    ) else $error("w_en and en_c high together");

endmodule

// File: hw/instr_decoder.sv
module instr_decoder (
    input  cpu_pkg::instr_u   ir,
    input  cpu_pkg::reg_sel_e reg_sel,
    output cpu_pkg::opcode_e  opcode,
    output cpu_pkg::alu_op_e  op,
    output cpu_pkg::shift_e   shift,
    output cpu_pkg::reg_idx_t reg_idx,
    output cpu_pkg::word_t    imm8_sx
);

    localparam int EXT_W = cpu_pkg::DATA_W - 8;

    // common fields sit in the same place in both views
    assign opcode = ir.imm.opcode;
    assign op     = ir.imm.op;
    assign shift  = ir.rg.shift;

    assign imm8_sx = {{EXT_W{ir.imm.imm8[7]}}, ir.imm.imm8};

    always_comb begin
        case (reg_sel)
            cpu_pkg::SEL_RM: begin
                reg_idx = ir.rg.rm;
            end
            cpu_pkg::SEL_RD: begin
                reg_idx = ir.rg.rd;
            end
            default: begin
                reg_idx = ir.imm.rn; // rn, also used by mov immediate
            end
        endcase
    end

endmodule

// File: hw/instr_fetch.sv
module instr_fetch #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] start_pc,
    input  logic              prog_we,
    input  logic [ADDR_W-1:0] prog_addr,
    input  cpu_pkg::word_t    prog_data,
    input  logic              load_ir,
    output cpu_pkg::instr_u   ir
);

    cpu_pkg::word_t    mem [2**ADDR_W];
    logic [ADDR_W-1:0] pc;

    // program port, only used while reset is held
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= start_pc; // rst_n high means reset
        end else if (load_ir) begin
            pc <= pc + 1'b1; // wraps at ADDR_W
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= mem[pc];
        end
    end

    // the running program may not be overwritten
    a_no_prog_in_run: assert property (
        @(posedge clk) !rst_n |-> !prog_we
    ) else $error("prog_we high while the core runs");

endmodule

// File: hw/cpu_ctrl_if.sv
interface cpu_ctrl_if;

    cpu_pkg::reg_sel_e reg_sel; // which field addresses the register file
    cpu_pkg::wb_sel_e  wb_sel;
    logic              w_en;
    logic              en_a;
    logic              en_b;
    logic              en_c;
    logic              sel_a;   // forces alu input a to zero
    cpu_pkg::alu_op_e  alu_op;

    modport seq (
        output reg_sel, wb_sel, w_en,
        output en_a, en_b, en_c,
        output sel_a, alu_op
    );

    modport dp (
        input reg_sel, wb_sel, w_en,
        input en_a, en_b, en_c,
        input sel_a, alu_op
    );

endinterface

// File: hw/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 16;
    localparam int REG_ADDR_W = 3;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // top three bits of the instruction, anything else runs as a no-op
    typedef enum logic [2:0] {
        OP_ALU  = 3'b101,
        OP_MOV  = 3'b110,
        OP_HALT = 3'b111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_AND = 2'b10,
        ALU_MVN = 2'b11
    } alu_op_e;

    // same field, read under OP_MOV
    localparam alu_op_e MOV_REG = ALU_ADD;
    localparam alu_op_e MOV_IMM = ALU_AND;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL  = 2'b01,
        SH_LSR  = 2'b10,
        SH_ASR  = 2'b11
    } shift_e;

    typedef enum logic [1:0] {
        SEL_RM = 2'b00,
        SEL_RD = 2'b01,
        SEL_RN = 2'b10
    } reg_sel_e;

    typedef enum logic {
        WB_RESULT = 1'b0, // register C
        WB_IMM8   = 1'b1
    } wb_sel_e;

    typedef enum logic [2:0] {
        FETCH, DECODE, LOAD_A, LOAD_B, EXEC, WRITE, HALT
    } state_e;

    typedef struct packed {
        opcode_e    opcode;
        alu_op_e    op;
        reg_idx_t   rn;
        logic [7:0] imm8;
    } instr_imm_t;

    typedef struct packed {
        opcode_e  opcode;
        alu_op_e  op;
        reg_idx_t rn;
        reg_idx_t rd;
        shift_e   shift;
        reg_idx_t rm;
    } instr_reg_t;

    typedef union packed {
        instr_imm_t imm;
        instr_reg_t rg;
    } instr_u;

endpackage
